/* proc_consts.svh */
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// Datapath and instruction word width
`define WORD_W 16

// Architectural register count
`define REG_CNT 8

// Register select width, log2 of REG_CNT
`define REG_SEL_W 3

// Opcode field, instruction bits 15 to 11
`define OPC_W 5

// Widest pc displacement, used by j
`define DISP_W 11

// Instruction memory, word addressed
`define IMEM_AW 8
`define IMEM_DEPTH (1 << `IMEM_AW)

// Data memory behind the bus, word addressed
`define DMEM_AW 6
`define DMEM_DEPTH (1 << `DMEM_AW)

`endif

/* isa_pkg.sv */
`include "proc_consts.svh"
`default_nettype none

package isa_pkg;

   // Opcodes, everything not listed is illegal
   typedef enum logic [`OPC_W-1:0] {
      op_halt = 5'b00000,
      op_nop  = 5'b00001,
      // R-format, rd <= rs op rt
      op_add  = 5'b01000,
      op_sub  = 5'b01001,
      op_and  = 5'b01010,
      op_xor  = 5'b01011,
      // Immediate forms
      op_addi = 5'b10000,
      op_lbi  = 5'b10001,
      // Memory access through Wishbone
      op_ld   = 5'b10100,
      op_st   = 5'b10101,
      // Forward-only control flow
      op_beqz = 5'b11000,
      op_j    = 5'b11100
   } opcode_e;

   // ALU function select
   typedef enum logic [2:0] {
      alu_add    = 3'd0,
      alu_sub    = 3'd1,
      alu_and    = 3'd2,
      alu_xor    = 3'd3,
      alu_pass_b = 3'd4
   } alu_op_e;

   // Register writeback source
   typedef enum logic [1:0] {
      wb_alu = 2'd0,
      wb_mem = 2'd1
   } wb_src_e;

   // Everything decode hands to the top level
   typedef struct packed {
      logic [`REG_SEL_W-1:0] rs_sel;
      logic [`REG_SEL_W-1:0] rt_sel;
      logic [`REG_SEL_W-1:0] wsel;
      logic                  reg_we;
      alu_op_e               alu_op;
      logic [`WORD_W-1:0]    imm;
      // ALU b from imm instead of rt
      logic                  use_imm;
      logic                  mem_en;
      logic                  mem_wr;
      wb_src_e               wb_src;
      logic                  branch;
      logic                  jump;
      // Unsigned, added to pc plus one
      logic [`DISP_W-1:0]    disp;
      logic                  halt;
      logic                  illegal;
   } ctrl_t;

endpackage

`default_nettype wire

/* bus_pkg.sv */
`default_nettype none

package bus_pkg;

   // Data RAM slave sequencing
   // One wait state, so each access spends one cycle in each state
   typedef enum logic {
      // Waiting for cyc and stb
      state_idle = 1'b0,
      // Ack high, write lands or read data driven
      state_ack  = 1'b1
   } wb_state_e;

endpackage

`default_nettype wire

/* wb_if.sv */
`include "proc_consts.svh"
`default_nettype none

// Wishbone classic, single master and single slave
interface wb_if;
   logic                cyc;
   logic                stb;
   logic                we;
   logic [`DMEM_AW-1:0] adr;
   logic [`WORD_W-1:0]  dat_m2s;
   logic [`WORD_W-1:0]  dat_s2m;
   logic                ack;

   // Core side
   modport master (
      output cyc, stb, we, adr, dat_m2s,
      input  dat_s2m, ack
   );

   // Memory side
   modport slave (
      input  cyc, stb, we, adr, dat_m2s,
      output dat_s2m, ack
   );
endinterface

`default_nettype wire

/* instr_mem.sv */
`include "proc_consts.svh"
`default_nettype none

module instr_mem (
   input  wire                 clk,
   // Program load, used by the testbench under reset
   input  wire                 prog_we,
   input  wire [`IMEM_AW-1:0]  prog_addr,
   input  wire [`WORD_W-1:0]   prog_data,
   // Fetch side
   input  wire [`IMEM_AW-1:0]  fetch_addr,
   output logic [`WORD_W-1:0]  instr
);

   // One instruction per word
   logic [`WORD_W-1:0] mem [`IMEM_DEPTH];

   // Load port writes at the edge
   always_ff @(posedge clk) begin
      if (prog_we) begin
         mem[prog_addr] <= prog_data;
      end
   end

   // Fetch is combinational, same cycle as pc
   assign instr = mem[fetch_addr];

endmodule

`default_nettype wire

/* reg_file.sv */
`include "proc_consts.svh"
`default_nettype none

module reg_file (
   input  wire                   clk,
   input  wire                   reset,
   // Two read ports
   input  wire [`REG_SEL_W-1:0]  rs_sel,
   input  wire [`REG_SEL_W-1:0]  rt_sel,
   output logic [`WORD_W-1:0]    rs_data,
   output logic [`WORD_W-1:0]    rt_data,
   // One write port
   input  wire                   we,
   input  wire [`REG_SEL_W-1:0]  wsel,
   input  wire [`WORD_W-1:0]     wdata
);

   logic [`WORD_W-1:0] regs [`REG_CNT];

   // All registers start at zero
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wsel] <= wdata;
      end
   end

   // Asynchronous reads
   // Write lands at the edge ending the instruction, before the next read
   assign rs_data = regs[rs_sel];
   assign rt_data = regs[rt_sel];

endmodule

`default_nettype wire

/* decode.sv */
`include "proc_consts.svh"
`default_nettype none

module decode import isa_pkg::*; (
   input  wire [`WORD_W-1:0] instr,
   output ctrl_t             ctrl
);

   opcode_e               opc;
   logic [`REG_SEL_W-1:0] rs;
   logic [`REG_SEL_W-1:0] rt;
   logic [`REG_SEL_W-1:0] rd;
   logic [`WORD_W-1:0]    imm5_sx;
   logic [`WORD_W-1:0]    imm8_sx;

   // Fixed field positions
   assign opc = opcode_e'(instr[15:11]);
   assign rs  = instr[10:8];
   assign rt  = instr[7:5];
   assign rd  = instr[4:2];

   // Sign-extended immediates
   assign imm5_sx = {{(`WORD_W-5){instr[4]}}, instr[4:0]};
   assign imm8_sx = {{(`WORD_W-8){instr[7]}}, instr[7:0]};

   always_comb begin
      // Defaults, no write and no bus cycle
      ctrl        = '0;
      ctrl.rs_sel = rs;
      ctrl.rt_sel = rt;
      ctrl.wsel   = rd;
      ctrl.alu_op = alu_add;
      ctrl.wb_src = wb_alu;
      ctrl.imm    = imm5_sx;
      // 11-bit j offset unless beqz narrows it
      ctrl.disp   = instr[`DISP_W-1:0];
      case (opc)
         op_halt: begin
            ctrl.halt = 1'b1;
         end
         op_nop: begin
            ctrl.halt = 1'b0;
         end
         // R-format, destination rd
         op_add, op_sub, op_and, op_xor: begin
            ctrl.reg_we = 1'b1;
            case (opc)
               op_sub:  ctrl.alu_op = alu_sub;
               op_and:  ctrl.alu_op = alu_and;
               op_xor:  ctrl.alu_op = alu_xor;
               default: ctrl.alu_op = alu_add;
            endcase
         end
         // rt <= rs + imm5
         op_addi: begin
            ctrl.reg_we  = 1'b1;
            ctrl.wsel    = rt;
            ctrl.use_imm = 1'b1;
         end
         // rs <= imm8, ALU just passes b through
         op_lbi: begin
            ctrl.reg_we  = 1'b1;
            ctrl.wsel    = rs;
            ctrl.imm     = imm8_sx;
            ctrl.use_imm = 1'b1;
            ctrl.alu_op  = alu_pass_b;
         end
         // Address is rs + imm5 in both cases
         op_ld: begin
            ctrl.reg_we  = 1'b1;
            ctrl.wsel    = rt;
            ctrl.use_imm = 1'b1;
            ctrl.mem_en  = 1'b1;
            ctrl.wb_src  = wb_mem;
         end
         op_st: begin
            ctrl.use_imm = 1'b1;
            ctrl.mem_en  = 1'b1;
            ctrl.mem_wr  = 1'b1;
         end
         // Unsigned 8-bit displacement
         op_beqz: begin
            ctrl.branch = 1'b1;
            ctrl.disp   = {{(`DISP_W-8){1'b0}}, instr[7:0]};
         end
         op_j: begin
            ctrl.jump = 1'b1;
         end
         // Anything else stops the core
         default: begin
            ctrl.illegal = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

/* alu.sv */
`include "proc_consts.svh"
`default_nettype none

module alu import isa_pkg::*; (
   input  wire [`WORD_W-1:0]  a,
   input  wire [`WORD_W-1:0]  b,
   input  wire alu_op_e       op,
   output logic [`WORD_W-1:0] result,
   output logic               zero
);

   always_comb begin
      case (op)
         alu_add: begin
            result = a + b;
         end
         alu_sub: begin
            result = a - b;
         end
         alu_and: begin
            result = a & b;
         end
         alu_xor: begin
            result = a ^ b;
         end
         // lbi, and anything unused
         default: begin
            result = b;
         end
      endcase
   end

   // Tests operand a, which is rs, for beqz
   assign zero = (a == '0);

endmodule

`default_nettype wire

/* data_mem_wb.sv */
`include "proc_consts.svh"
`default_nettype none

module data_mem_wb import bus_pkg::*; (
   input  wire  clk,
   input  wire  reset,
   wb_if.slave  bus
);

   wb_state_e          state;
   logic [`WORD_W-1:0] mem [`DMEM_DEPTH];

   // Slave FSM, idle then one ack cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= state_idle;
      end else begin
         case (state)
            state_idle: begin
               // First cycle of the request is the wait state
               if (bus.cyc && bus.stb) begin
                  state <= state_ack;
               end
            end
            default: begin
               state <= state_idle;
            end
         endcase
      end
   end

   // RAM contents, cleared on reset
   // Write commits on the ack edge
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `DMEM_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (state == state_ack && bus.we) begin
         mem[bus.adr] <= bus.dat_m2s;
      end
   end

   assign bus.ack     = (state == state_ack);
   // Read data valid only while ack is up
   assign bus.dat_s2m = bus.ack ? mem[bus.adr] : '0;

endmodule

`default_nettype wire

/* proc.sv */
`include "proc_consts.svh"
`default_nettype none

module proc import isa_pkg::*; (
   input  wire                   clk,
   input  wire                   reset,
   // Program load port
   input  wire                   prog_we,
   input  wire [`IMEM_AW-1:0]    prog_addr,
   input  wire [`WORD_W-1:0]     prog_data,
   // Status
   output logic                  halt,
   output logic                  err,
   // Register write trace
   output logic                  rf_we,
   output logic [`REG_SEL_W-1:0] rf_waddr,
   output logic [`WORD_W-1:0]    rf_wdata
);

   // Fetch
   logic [`IMEM_AW-1:0] pc;
   logic [`IMEM_AW-1:0] pc_inc;
   logic [`IMEM_AW-1:0] pc_target;
   logic [`IMEM_AW-1:0] next_pc;
   logic [`WORD_W-1:0]  instr;
   // Decode and execute
   ctrl_t               ctrl;
   logic [`WORD_W-1:0]  rs_data;
   logic [`WORD_W-1:0]  rt_data;
   logic [`WORD_W-1:0]  alu_b;
   logic [`WORD_W-1:0]  alu_out;
   logic                alu_zero;
   // Sequencing
   logic                run;
   logic                active;
   logic                mem_wait;
   logic                take;

   wb_if bus ();

   instr_mem imem (
      .clk        (clk),
      .prog_we    (prog_we),
      .prog_addr  (prog_addr),
      .prog_data  (prog_data),
      .fetch_addr (pc),
      .instr      (instr)
   );

   decode dcd (
      .instr (instr),
      .ctrl  (ctrl)
   );

   reg_file rf (
      .clk     (clk),
      .reset   (reset),
      .rs_sel  (ctrl.rs_sel),
      .rt_sel  (ctrl.rt_sel),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .we      (rf_we),
      .wsel    (rf_waddr),
      .wdata   (rf_wdata)
   );

   // Second operand is either rt or the immediate
   assign alu_b = ctrl.use_imm ? ctrl.imm : rt_data;

   alu ex_alu (
      .a      (rs_data),
      .b      (alu_b),
      .op     (ctrl.alu_op),
      .result (alu_out),
      .zero   (alu_zero)
   );

   data_mem_wb dmem (
      .clk   (clk),
      .reset (reset),
      .bus   (bus)
   );

   // Core executes once out of reset and until halted
   assign active = run && !halt;

   // Loads and stores sit here until the slave acks
   assign mem_wait = ctrl.mem_en && !bus.ack;

   // Wishbone master, held steady by the pc stall
   assign bus.cyc     = active && ctrl.mem_en;
   assign bus.stb     = active && ctrl.mem_en;
   assign bus.we      = ctrl.mem_wr;
   assign bus.adr     = alu_out[`DMEM_AW-1:0];
   assign bus.dat_m2s = rt_data;

   // Writeback
   // Loads write only in the ack cycle, stores never
   assign rf_we    = active && ctrl.reg_we && (!ctrl.mem_en || bus.ack);
   assign rf_waddr = ctrl.wsel;
   assign rf_wdata = (ctrl.wb_src == wb_mem) ? bus.dat_s2m : alu_out;

   // Next pc
   assign pc_inc    = pc + 1'b1;
   assign pc_target = pc_inc + ctrl.disp[`IMEM_AW-1:0];
   assign take      = ctrl.jump || (ctrl.branch && alu_zero);

   always_comb begin
      if (!active || mem_wait || ctrl.halt || ctrl.illegal) begin
         // Frozen, stalled or stopping
         next_pc = pc;
      end else if (take) begin
         next_pc = pc_target;
      end else begin
         next_pc = pc_inc;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc   <= '0;
         run  <= 1'b0;
         halt <= 1'b0;
         err  <= 1'b0;
      end else begin
         // First instruction issues the cycle after reset drops
         run <= 1'b1;
         pc  <= next_pc;
         // Halt and illegal both stop the core, only illegal flags err
         if (active && (ctrl.halt || ctrl.illegal)) begin
            halt <= 1'b1;
         end
         if (active && ctrl.illegal) begin
            err <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* tb_proc.sv */
`include "proc_consts.svh"
`default_nettype none

module tb_proc;

   // Opcode encodings of the ISA
   localparam logic [4:0] op_halt = 5'b00000;
   localparam logic [4:0] op_nop  = 5'b00001;
   localparam logic [4:0] op_add  = 5'b01000;
   localparam logic [4:0] op_sub  = 5'b01001;
   localparam logic [4:0] op_and  = 5'b01010;
   localparam logic [4:0] op_xor  = 5'b01011;
   localparam logic [4:0] op_addi = 5'b10000;
   localparam logic [4:0] op_lbi  = 5'b10001;
   localparam logic [4:0] op_ld   = 5'b10100;
   localparam logic [4:0] op_st   = 5'b10101;
   localparam logic [4:0] op_beqz = 5'b11000;
   localparam logic [4:0] op_j    = 5'b11100;

   localparam int n_prog = 8;
   // Load, reset, worst-case run and the quiet window after halt
   localparam int test_cycles = 64 + 8 + 64 * 3 + 24;

   logic        clk;
   logic        reset;
   logic        prog_we;
   logic [7:0]  prog_addr;
   logic [15:0] prog_data;
   logic        halt;
   logic        err;
   logic        rf_we;
   logic [2:0]  rf_waddr;
   logic [15:0] rf_wdata;

   logic [31:0] lfsr;
   logic [15:0] prog [64];
   int          len;
   int          bad_pos;
   int          errors;
   int          checks;
   // Reference model state and expected write trace
   logic [15:0] model_regs [8];
   logic        exp_err;
   logic [2:0]  exp_waddr [$];
   logic [15:0] exp_wdata [$];

   proc proc_i (
      .clk       (clk),
      .reset     (reset),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .halt      (halt),
      .err       (err),
      .rf_we     (rf_we),
      .rf_waddr  (rf_waddr),
      .rf_wdata  (rf_wdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   function automatic string kind_name(input int kind);
      case (kind)
         0: return "alu";
         1: return "memory";
         2: return "branch";
         default: return "illegal";
      endcase
   endfunction

   // Kind 0 arithmetic, 1 adds memory, 2 adds control flow, 3 all plus an illegal opcode
   task automatic build_program(input int kind);
      int p;
      int r;
      int maxd;
      int d;
      len = 40 + int'(rand_bits(5) % 21);
      bad_pos = 10 + int'(rand_bits(5) % 20);
      p = 0;
      while (p < len - 1) begin
         r = int'(rand_bits(3));
         if (((kind == 1 && r >= 5) || (kind == 3 && r == 5)) && p < len - 2) begin
            // Small base and offset so loads often hit stored words
            prog[p] = {op_lbi, 3'(rand_bits(3)), 4'b0000, 4'(rand_bits(4))};
            prog[p+1] = {rand_bits(1) ? op_ld : op_st, prog[p][10:8], 3'(rand_bits(3)),
                         3'b000, 2'(rand_bits(2))};
            p = p + 2;
         end else if ((kind == 2 && r >= 5) || (kind == 3 && r >= 6)) begin
            // Forward only and never past halt or the illegal word
            maxd = (kind == 3 && p < bad_pos) ? bad_pos - 1 - p : len - 2 - p;
            d = int'(rand_bits(4));
            if (d > maxd) begin
               d = maxd;
            end
            if (rand_bits(1) == 1) begin
               prog[p] = {op_beqz, 3'(rand_bits(3)), 8'(d)};
            end else begin
               prog[p] = {op_j, 11'(d)};
            end
            p++;
         end else begin
            case (3'(rand_bits(3)))
               3'd0: prog[p] = {op_add, 9'(rand_bits(9)), 2'b00};
               3'd1: prog[p] = {op_sub, 9'(rand_bits(9)), 2'b00};
               3'd2: prog[p] = {op_and, 9'(rand_bits(9)), 2'b00};
               3'd3: prog[p] = {op_xor, 9'(rand_bits(9)), 2'b00};
               3'd4, 3'd7: prog[p] = {op_addi, 11'(rand_bits(11))};
               3'd5: prog[p] = {op_lbi, 11'(rand_bits(11))};
               default: prog[p] = {op_nop, 11'd0};
            endcase
            p++;
         end
      end
      prog[len-1] = {op_halt, 11'd0};
      // Unused opcodes
      if (kind == 3) begin
         case (2'(rand_bits(2)))
            2'd0: prog[bad_pos] = {5'b00010, 11'(rand_bits(11))};
            2'd1: prog[bad_pos] = {5'b00110, 11'(rand_bits(11))};
            2'd2: prog[bad_pos] = {5'b01111, 11'(rand_bits(11))};
            default: prog[bad_pos] = {5'b11111, 11'(rand_bits(11))};
         endcase
      end
   endtask

   task automatic model_write(input logic [2:0] sel, input logic [15:0] val);
      model_regs[sel] = val;
      exp_waddr.push_back(sel);
      exp_wdata.push_back(val);
   endtask

   // ISA reference model running the program from pc 0 with cleared state
   task automatic run_model();
      logic [15:0] dm [64];
      logic [15:0] ins;
      logic [15:0] a;
      logic [15:0] sx5;
      logic [2:0]  rs;
      logic [2:0]  rt;
      int          pc;
      int          steps;
      bit          done;
      for (int i = 0; i < 64; i++) begin
         dm[i] = '0;
      end
      for (int i = 0; i < 8; i++) begin
         model_regs[i] = '0;
      end
      exp_waddr.delete();
      exp_wdata.delete();
      exp_err = 1'b0;
      pc = 0;
      steps = 0;
      done = 1'b0;
      while (!done && steps < 256) begin
         ins = prog[pc];
         rs = ins[10:8];
         rt = ins[7:5];
         sx5 = {{11{ins[4]}}, ins[4:0]};
         a = model_regs[rs] + sx5;
         pc++;
         steps++;
         case (ins[15:11])
            op_halt: done = 1'b1;
            op_nop: ;
            op_add: model_write(ins[4:2], model_regs[rs] + model_regs[rt]);
            op_sub: model_write(ins[4:2], model_regs[rs] - model_regs[rt]);
            op_and: model_write(ins[4:2], model_regs[rs] & model_regs[rt]);
            op_xor: model_write(ins[4:2], model_regs[rs] ^ model_regs[rt]);
            op_addi: model_write(rt, a);
            op_lbi: model_write(rs, {{8{ins[7]}}, ins[7:0]});
            op_ld: model_write(rt, dm[a[5:0]]);
            op_st: dm[a[5:0]] = model_regs[rt];
            op_beqz: pc = (model_regs[rs] == 16'd0) ? pc + int'(ins[7:0]) : pc;
            op_j: pc = pc + int'(ins[10:0]);
            default: begin
               exp_err = 1'b1;
               done = 1'b1;
            end
         endcase
      end
   endtask

   task automatic run_test(input int num, input int kind);
      int errs_before;
      int n_writes;
      errs_before = errors;
      @(posedge clk);
      #2;
      reset = 1'b1;
      build_program(kind);
      run_model();
      n_writes = exp_waddr.size();
      // Program load while the core is held
      for (int i = 0; i < len; i++) begin
         prog_we = 1'b1;
         prog_addr = 8'(i);
         prog_data = prog[i];
         @(posedge clk);
         #2;
      end
      prog_we = 1'b0;
      repeat (8) begin
         @(negedge clk);
         check_value("halt", 32'(halt), 32'd0);
         check_value("err", 32'(err), 32'd0);
         check_value("rf_we", 32'(rf_we), 32'd0);
      end
      @(posedge clk);
      #2;
      reset = 1'b0;
      while (halt !== 1'b1) begin
         @(negedge clk);
      end
      check_value("writes left", 32'(exp_waddr.size()), 32'd0);
      check_value("err", 32'(err), 32'(exp_err));
      // Monitor flags any write in this window
      repeat (20) @(negedge clk);
      check_value("halt", 32'(halt), 32'd1);
      $display("test %0d %s: %0d instructions, %0d writes, %s", num, kind_name(kind), len,
               n_writes, (errors == errs_before) ? "ok" : "FAILED");
   endtask

   // Write trace checked in order against the model
   always @(negedge clk) begin
      if (rf_we === 1'b1) begin
         if (exp_waddr.size() == 0) begin
            errors++;
            $display("error at %0t: register write to r%0d that the model does not make",
                     $time, rf_waddr);
         end else begin
            check_value("rf_waddr", 32'(rf_waddr), 32'(exp_waddr.pop_front()));
            check_value("rf_wdata", 32'(rf_wdata), 32'(exp_wdata.pop_front()));
         end
      end
   end

   initial begin
      #(n_prog * test_cycles * 20 + 200);
      $display("watchdog expired before all programs halted");
      $display("Done: errors found");
      $finish;
   end

   initial begin
      reset = 1'b1;
      prog_we = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      lfsr = 32'ha1e0;
      errors = 0;
      checks = 0;
      for (int t = 0; t < n_prog; t++) begin
         run_test(t, t % 4);
      end
      $display("tests %0d, checks %0d, errors %0d", n_prog, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
isa_pkg.sv
bus_pkg.sv
wb_if.sv
instr_mem.sv
reg_file.sv
decode.sv
alu.sv
data_mem_wb.sv
proc.sv
tb_proc.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_proc \
   --Mdir obj_dir -o sim_proc

./obj_dir/sim_proc | tee sim.log

if grep -qx "Done: no errors" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi
